// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= mem_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/mem_tb.sv
// Memory stage testbench
`timescale 1ns/1ps
`default_nettype none

module mem_tb
  import mem_pkg::*;
();

  localparam int          clk_period_lp = 40;
  localparam int          tlb_els_lp    = 4;
  localparam int          ram_words_lp  = 128;
  localparam logic [31:0] lfsr_seed_lp  = 32'h9bc94361;
  localparam logic [31:0] lfsr_taps_lp  = 32'h80200003;

  typedef struct packed {
    logic      cmd_v;
    mmu_cmd_s  cmd;
    mmu_cfg_s  cfg;
    logic      poison;
    logic      fill_v;
    tlb_fill_s fill;
    logic      flush;
    logic      exp_v;
    mem_resp_s exp;
  } row_s;

  logic      clk;
  logic      reset;
  mmu_cmd_s  mmu_cmd_i;
  logic      mmu_cmd_v_i;
  mmu_cfg_s  cfg_i;
  logic      chk_poison_i;
  logic      tlb_fill_v_i;
  tlb_fill_s tlb_fill_i;
  logic      tlb_flush_i;
  mem_resp_s mem_resp_o;
  logic      mem_resp_v_o;

  row_s                   rows[$];
  mem_resp_s              exp_q[$];
  tlb_entry_s             model_tlb[logic [VTAG_WIDTH-1:0]];
  logic [DWORD_WIDTH-1:0] model_mem[ram_words_lp];
  logic [31:0]            lfsr_state;
  logic                   table_ready = 1'b0;
  int                     watchdog_ns;
  int                     checked_count = 0;
  int                     value_errors = 0;
  int                     other_errors = 0;

  mem_tb_clock #(
    .period_ns_p    (clk_period_lp),
    .reset_cycles_p (4)
  ) clock_i (
    .clk_o   (clk),
    .reset_o (reset)
  );

  mem_top #(
    .tlb_els_p   (tlb_els_lp),
    .ram_words_p (ram_words_lp)
  ) dut_i (
    .clk_i        (clk),
    .reset_i      (reset),
    .mmu_cmd_i    (mmu_cmd_i),
    .mmu_cmd_v_i  (mmu_cmd_v_i),
    .cfg_i        (cfg_i),
    .chk_poison_i (chk_poison_i),
    .tlb_fill_v_i (tlb_fill_v_i),
    .tlb_fill_i   (tlb_fill_i),
    .tlb_flush_i  (tlb_flush_i),
    .mem_resp_o   (mem_resp_o),
    .mem_resp_v_o (mem_resp_v_o)
  );

  // One output bit per LFSR step
  function automatic logic [DWORD_WIDTH-1:0] next_rand_dword();
    logic [DWORD_WIDTH-1:0] value;
    logic                   out_bit;
    value = '0;
    for (int b = 0; b < DWORD_WIDTH; b++) begin
      out_bit    = lfsr_state[0];
      lfsr_state = (lfsr_state >> 1) ^ (out_bit ? lfsr_taps_lp : 32'h0);
      value      = {value[DWORD_WIDTH-2:0], out_bit};
    end
    return value;
  endfunction

  function automatic int access_bytes(input mem_op_e op);
    case (op)
      e_lb, e_lbu, e_sb: return 1;
      e_lh, e_lhu, e_sh: return 2;
      e_lw, e_lwu, e_sw: return 4;
      default:           return 8;
    endcase
  endfunction

  function automatic logic [DWORD_WIDTH-1:0] extend_load(input mem_op_e op,
                                                          input logic [DWORD_WIDTH-1:0] dword,
                                                          input logic [2:0] off);
    logic [DWORD_WIDTH-1:0] v;
    v = dword >> (8 * off);
    case (op)
      e_lb:    return {{56{v[7]}}, v[7:0]};
      e_lbu:   return {56'h0, v[7:0]};
      e_lh:    return {{48{v[15]}}, v[15:0]};
      e_lhu:   return {48'h0, v[15:0]};
      e_lw:    return {{32{v[31]}}, v[31:0]};
      e_lwu:   return {32'h0, v[31:0]};
      default: return v;
    endcase
  endfunction

  function automatic mmu_cfg_s make_cfg(input logic en, input priv_e priv, input logic sum);
    mmu_cfg_s c;
    c.translation_en = en;
    c.priv           = priv;
    c.sum            = sum;
    return c;
  endfunction

  function automatic logic [VADDR_WIDTH-1:0] make_vaddr(input logic [VTAG_WIDTH-1:0] vtag,
                                                        input logic [PAGE_OFFSET_WIDTH-1:0] off);
    return {vtag, off};
  endfunction

  // Appends one row and works out its response from a model of TLB and memory
  task automatic add_row(input logic cmd_v, input mem_op_e op,
                         input logic [VADDR_WIDTH-1:0] vaddr, input mmu_cfg_s cfg,
                         input logic poison, input logic fill_v, input tlb_fill_s fill,
                         input logic flush);
    row_s                         r;
    logic [VTAG_WIDTH-1:0]        vtag;
    logic [PAGE_OFFSET_WIDTH-1:0] off;
    logic [PTAG_WIDTH-1:0]        ptag;
    tlb_entry_s                   ent;
    logic                         store;
    logic                         priv_bad;
    logic                         write_bad;
    int                           idx;
    r          = '0;
    r.cmd_v    = cmd_v;
    r.cmd.mem_op = op;
    r.cmd.vaddr  = vaddr;
    r.cfg      = cfg;
    r.poison   = poison;
    r.fill_v   = fill_v;
    r.fill     = fill;
    r.flush    = flush;
    store      = op inside {e_sb, e_sh, e_sw, e_sd};
    if (cmd_v && store) begin
      r.cmd.data = next_rand_dword();
    end
    if (flush) begin
      model_tlb.delete();
    end
    if (fill_v) begin
      model_tlb[fill.vtag] = fill.entry;
    end
    vtag        = vaddr[VADDR_WIDTH-1 -: VTAG_WIDTH];
    off         = vaddr[PAGE_OFFSET_WIDTH-1:0];
    ptag        = vtag[PTAG_WIDTH-1:0];
    r.exp_v     = cmd_v && !poison;
    r.exp.fault = e_no_fault;
    if (cfg.translation_en) begin
      if (!model_tlb.exists(vtag)) begin
        r.exp.miss_v = 1'b1;
      end else begin
        ent       = model_tlb[vtag];
        ptag      = ent.ptag;
        priv_bad  = ((cfg.priv == e_priv_s) && !cfg.sum && ent.u)
                  || ((cfg.priv == e_priv_u) && !ent.u);
        write_bad = store && !(ent.w && ent.d);
        if (priv_bad || write_bad) begin
          r.exp.fault = store ? e_store_page_fault : e_load_page_fault;
        end
      end
    end
    if (!r.exp.miss_v && r.exp.fault == e_no_fault
        && ptag[PTAG_WIDTH-1 -: DID_WIDTH] != '0) begin
      r.exp.fault = store ? e_store_access_fault : e_load_access_fault;
    end
    r.exp.exc_v = (r.exp.fault != e_no_fault);
    idx = (int'({ptag, off}) / DWORD_BYTES) % ram_words_lp;
    if (cmd_v && !r.exp.miss_v && !r.exp.exc_v) begin
      if (store && !poison) begin
        for (int b = 0; b < access_bytes(op); b++) begin
          model_mem[idx][8*(int'(off[2:0]) + b) +: 8] = r.cmd.data[8*b +: 8];
        end
      end else if (!store) begin
        r.exp.data = extend_load(op, model_mem[idx], off[2:0]);
      end
    end
    rows.push_back(r);
  endtask

  task automatic send_cmd(input mem_op_e op, input logic [VADDR_WIDTH-1:0] va,
                          input mmu_cfg_s cfg);
    add_row(1'b1, op, va, cfg, 1'b0, 1'b0, '0, 1'b0);
  endtask

  task automatic poison_cmd(input mem_op_e op, input logic [VADDR_WIDTH-1:0] va,
                            input mmu_cfg_s cfg);
    add_row(1'b1, op, va, cfg, 1'b1, 1'b0, '0, 1'b0);
  endtask

  task automatic fill_tlb(input logic [VTAG_WIDTH-1:0] vtag, input logic [PTAG_WIDTH-1:0] ptag,
                          input logic u, input logic w, input logic d);
    tlb_fill_s f;
    f = {vtag, ptag, u, w, d};
    add_row(1'b0, e_lb, '0, make_cfg(1'b0, e_priv_m, 1'b0), 1'b0, 1'b1, f, 1'b0);
  endtask

  task automatic flush_tlb();
    add_row(1'b0, e_lb, '0, make_cfg(1'b0, e_priv_m, 1'b0), 1'b0, 1'b0, '0, 1'b1);
  endtask

  task automatic build_table();
    mmu_cfg_s bare;
    mmu_cfg_s m_on;
    mmu_cfg_s s_on;
    mmu_cfg_s s_sum;
    mmu_cfg_s u_on;
    bare  = make_cfg(1'b0, e_priv_m, 1'b0);
    m_on  = make_cfg(1'b1, e_priv_m, 1'b0);
    s_on  = make_cfg(1'b1, e_priv_s, 1'b0);
    s_sum = make_cfg(1'b1, e_priv_s, 1'b1);
    u_on  = make_cfg(1'b1, e_priv_u, 1'b0);
    // Every load size over one dword
    send_cmd(e_sd, make_vaddr(12'h000, 8'h10), bare);
    for (int o = 0; o < 8; o++) begin
      send_cmd(e_lb, make_vaddr(12'h000, 8'h10 + 8'(o)), bare);
      send_cmd(e_lbu, make_vaddr(12'h000, 8'h10 + 8'(o)), bare);
    end
    for (int o = 0; o < 8; o += 2) begin
      send_cmd(e_lh, make_vaddr(12'h000, 8'h10 + 8'(o)), bare);
      send_cmd(e_lhu, make_vaddr(12'h000, 8'h10 + 8'(o)), bare);
    end
    for (int o = 0; o < 8; o += 4) begin
      send_cmd(e_lw, make_vaddr(12'h000, 8'h10 + 8'(o)), bare);
      send_cmd(e_lwu, make_vaddr(12'h000, 8'h10 + 8'(o)), bare);
    end
    send_cmd(e_ld, make_vaddr(12'h000, 8'h10), bare);
    // Narrow stores merge into one dword
    send_cmd(e_sd, make_vaddr(12'h000, 8'h18), bare);
    send_cmd(e_sb, make_vaddr(12'h000, 8'h19), bare);
    send_cmd(e_sh, make_vaddr(12'h000, 8'h1a), bare);
    send_cmd(e_sw, make_vaddr(12'h000, 8'h1c), bare);
    send_cmd(e_ld, make_vaddr(12'h000, 8'h18), bare);
    send_cmd(e_lbu, make_vaddr(12'h000, 8'h19), bare);
    send_cmd(e_lh, make_vaddr(12'h000, 8'h1a), bare);
    send_cmd(e_lw, make_vaddr(12'h000, 8'h1c), bare);
    // Translation, then remap of the same vtag
    fill_tlb(12'h0a5, 6'h02, 1'b0, 1'b1, 1'b1);
    send_cmd(e_sd, make_vaddr(12'h0a5, 8'h40), m_on);
    send_cmd(e_ld, make_vaddr(12'h0a5, 8'h40), m_on);
    send_cmd(e_ld, make_vaddr(12'h002, 8'h40), bare);
    fill_tlb(12'h0a5, 6'h03, 1'b0, 1'b1, 1'b1);
    send_cmd(e_sd, make_vaddr(12'h0a5, 8'h40), m_on);
    send_cmd(e_ld, make_vaddr(12'h003, 8'h40), bare);
    send_cmd(e_ld, make_vaddr(12'h002, 8'h40), bare);
    send_cmd(e_lw, make_vaddr(12'h0a5, 8'h44), m_on);
    // Misses
    send_cmd(e_ld, make_vaddr(12'h1ff, 8'h00), m_on);
    send_cmd(e_sd, make_vaddr(12'h1ff, 8'h08), m_on);
    flush_tlb();
    send_cmd(e_ld, make_vaddr(12'h0a5, 8'h40), m_on);
    // Four mappings of physical page 1 with different permissions
    send_cmd(e_sd, make_vaddr(12'h001, 8'h80), bare);
    send_cmd(e_sd, make_vaddr(12'h001, 8'h88), bare);
    fill_tlb(12'h011, 6'h01, 1'b1, 1'b1, 1'b1);
    fill_tlb(12'h022, 6'h01, 1'b0, 1'b1, 1'b1);
    fill_tlb(12'h033, 6'h01, 1'b0, 1'b0, 1'b1);
    fill_tlb(12'h044, 6'h01, 1'b0, 1'b1, 1'b0);
    send_cmd(e_ld, make_vaddr(12'h011, 8'h80), s_on);
    send_cmd(e_ld, make_vaddr(12'h011, 8'h80), s_sum);
    send_cmd(e_sd, make_vaddr(12'h011, 8'h80), s_on);
    send_cmd(e_ld, make_vaddr(12'h022, 8'h80), u_on);
    send_cmd(e_ld, make_vaddr(12'h011, 8'h80), u_on);
    send_cmd(e_sd, make_vaddr(12'h022, 8'h80), u_on);
    send_cmd(e_sd, make_vaddr(12'h033, 8'h80), s_on);
    send_cmd(e_sd, make_vaddr(12'h044, 8'h80), s_on);
    send_cmd(e_sd, make_vaddr(12'h033, 8'h80), m_on);
    send_cmd(e_ld, make_vaddr(12'h011, 8'h80), m_on);
    send_cmd(e_sd, make_vaddr(12'h022, 8'h88), m_on);
    send_cmd(e_ld, make_vaddr(12'h001, 8'h80), bare);
    send_cmd(e_ld, make_vaddr(12'h001, 8'h88), bare);
    // Non-zero domain bits, the store aliases page 1 if it wrote
    send_cmd(e_ld, make_vaddr(12'h010, 8'h80), bare);
    send_cmd(e_sd, make_vaddr(12'h031, 8'h80), bare);
    send_cmd(e_ld, make_vaddr(12'h001, 8'h80), bare);
    flush_tlb();
    fill_tlb(12'h055, 6'h21, 1'b0, 1'b1, 1'b1);
    send_cmd(e_sd, make_vaddr(12'h055, 8'h88), m_on);
    send_cmd(e_lwu, make_vaddr(12'h055, 8'h8c), m_on);
    send_cmd(e_ld, make_vaddr(12'h001, 8'h88), bare);
    // Poisoned store between live neighbours
    send_cmd(e_sd, make_vaddr(12'h001, 8'h90), bare);
    poison_cmd(e_sd, make_vaddr(12'h001, 8'h90), bare);
    send_cmd(e_ld, make_vaddr(12'h001, 8'h90), bare);
    send_cmd(e_lb, make_vaddr(12'h001, 8'h91), bare);
  endtask

  task automatic check_fault(input fault_e exp, input fault_e act);
    if (act !== exp) begin
      $display("** Error: mem_resp_o.fault expected %h actual %h at %0t", exp, act, $time);
      value_errors++;
    end
  endtask

  task automatic check_resp(input mem_resp_s exp, input mem_resp_s act);
    if (act.data !== exp.data) begin
      $display("** Error: mem_resp_o.data expected %h actual %h at %0t",
               exp.data, act.data, $time);
      value_errors++;
    end
    if (act.miss_v !== exp.miss_v) begin
      $display("** Error: mem_resp_o.miss_v expected %h actual %h at %0t",
               exp.miss_v, act.miss_v, $time);
      value_errors++;
    end
    if (act.exc_v !== exp.exc_v) begin
      $display("** Error: mem_resp_o.exc_v expected %h actual %h at %0t",
               exp.exc_v, act.exc_v, $time);
      value_errors++;
    end
    check_fault(exp.fault, act.fault);
  endtask

  // Cfg and poison belong to the command one cycle behind the one being sent
  task automatic apply_row(input int i);
    mmu_cmd_i    = rows[i].cmd;
    mmu_cmd_v_i  = rows[i].cmd_v;
    tlb_fill_v_i = rows[i].fill_v;
    tlb_fill_i   = rows[i].fill;
    tlb_flush_i  = rows[i].flush;
    cfg_i        = (i > 0) ? rows[i-1].cfg : '0;
    chk_poison_i = (i > 0) ? rows[i-1].poison : 1'b0;
    if (rows[i].exp_v) begin
      exp_q.push_back(rows[i].exp);
    end
  endtask

  always @(negedge clk) begin
    if (!reset && mem_resp_v_o) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected response from the DUT at %0t with no command outstanding", $time);
        other_errors++;
      end else begin
        check_resp(exp_q.pop_front(), mem_resp_o);
        checked_count++;
      end
    end
  end

  initial begin
    wait (table_ready);
    #(watchdog_ns);
    $display("Timeout after %0d ns with %0d responses still outstanding",
             watchdog_ns, exp_q.size());
    $display("Checked %0d responses, %0d value errors, %0d other errors",
             checked_count, value_errors, other_errors);
    $display("Test failed");
    $finish;
  end

  initial begin
    mmu_cmd_i    = '0;
    mmu_cmd_v_i  = 1'b0;
    cfg_i        = '0;
    chk_poison_i = 1'b0;
    tlb_fill_v_i = 1'b0;
    tlb_fill_i   = '0;
    tlb_flush_i  = 1'b0;
    lfsr_state   = lfsr_seed_lp;
    build_table();
    watchdog_ns  = (rows.size() + 16) * clk_period_lp + 2000;
    table_ready  = 1'b1;
    @(negedge clk);
    while (reset) @(negedge clk);
    for (int i = 0; i < rows.size(); i++) begin
      @(negedge clk);
      apply_row(i);
    end
    @(negedge clk);
    mmu_cmd_v_i  = 1'b0;
    tlb_fill_v_i = 1'b0;
    tlb_flush_i  = 1'b0;
    cfg_i        = rows[rows.size()-1].cfg;
    chk_poison_i = rows[rows.size()-1].poison;
    @(negedge clk);
    chk_poison_i = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    // Idle a little to catch stray responses
    repeat (3) @(negedge clk);
    $display("Checked %0d responses, %0d value errors, %0d other errors",
             checked_count, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/mem_tb_clock.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module mem_tb_clock #(
  parameter int period_ns_p    = 40,
  parameter int reset_cycles_p = 4
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(period_ns_p / 2) clk_o = ~clk_o;
  end

  // Release reset away from the sampling edge
  initial begin
    reset_o = 1'b1;
    repeat (reset_cycles_p) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

// File: list.f
src/mem_pkg.sv
src/data_ram.sv
src/dtlb.sv
src/mem_decode.sv
src/mem_execute.sv
src/mem_result.sv
src/mem_top.sv
bench/mem_tb_clock.sv
bench/mem_tb.sv

// File: src/data_ram.sv
// Byte-masked data RAM
`timescale 1ns/1ps
`default_nettype none

module data_ram
  import mem_pkg::*;
#(
  parameter int ram_words_p = 128
) (
  input  logic                           clk_i,
  input  logic                           we_i,
  input  logic [$clog2(ram_words_p)-1:0] addr_i,
  input  logic [DWORD_WIDTH-1:0]         wdata_i,
  input  logic [DWORD_BYTES-1:0]         wmask_i,
  output logic [DWORD_WIDTH-1:0]         rdata_o
);

  logic [DWORD_WIDTH-1:0] mem_r [ram_words_p];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int b = 0; b < DWORD_BYTES; b++) begin
        if (wmask_i[b]) begin
          mem_r[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
    rdata_o <= mem_r[addr_i];
  end

endmodule

`default_nettype wire

// File: src/dtlb.sv
// Fully associative data TLB
`timescale 1ns/1ps
`default_nettype none

module dtlb
  import mem_pkg::*;
#(
  parameter int tlb_els_p = 4
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  flush_i,
  input  logic                  fill_v_i,
  input  tlb_fill_s             fill_i,
  input  logic [VTAG_WIDTH-1:0] vtag_i,
  output logic                  hit_o,
  output tlb_entry_s            entry_o
);

  localparam int idx_width_lp = (tlb_els_p > 1) ? $clog2(tlb_els_p) : 1;

  logic [tlb_els_p-1:0]    valid_r;
  logic [VTAG_WIDTH-1:0]   vtag_r [tlb_els_p];
  tlb_entry_s              entry_r [tlb_els_p];
  logic [idx_width_lp-1:0] victim_r;
  logic [tlb_els_p-1:0]    hit_vec;
  logic [tlb_els_p-1:0]    fill_match;
  logic [idx_width_lp-1:0] fill_match_idx;
  logic [idx_width_lp-1:0] fill_idx;

  always_comb begin
    entry_o        = '0;
    fill_match_idx = '0;
    for (int i = 0; i < tlb_els_p; i++) begin
      hit_vec[i]    = valid_r[i] && (vtag_r[i] == vtag_i);
      fill_match[i] = valid_r[i] && (vtag_r[i] == fill_i.vtag);
      if (hit_vec[i]) begin
        entry_o = entry_r[i];
      end
      if (fill_match[i]) begin
        fill_match_idx = idx_width_lp'(i);
      end
    end
  end

  assign hit_o = |hit_vec;

  // Refill an existing mapping in place, else take the round-robin slot
  assign fill_idx = (|fill_match) ? fill_match_idx : victim_r;

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_r  <= '0;
      victim_r <= '0;
    end else if (fill_v_i) begin
      valid_r[fill_idx] <= 1'b1;
      if (!(|fill_match)) begin
        victim_r <= (victim_r == idx_width_lp'(tlb_els_p - 1)) ? '0 : victim_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      vtag_r[fill_idx]  <= fill_i.vtag;
      entry_r[fill_idx] <= fill_i.entry;
    end
  end

  a_one_hit: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(hit_vec))
    else $error("multiple TLB entries hit vtag %0h", vtag_i);

endmodule

`default_nettype wire

// File: src/mem_decode.sv
// Command decode stage
`timescale 1ns/1ps
`default_nettype none

module mem_decode
  import mem_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  mmu_cmd_s mmu_cmd_i,
  input  logic     mmu_cmd_v_i,
  output dec_pkt_s dec_pkt_o
);

  dec_pkt_s                     dec_pkt_n;
  dec_pkt_s                     dec_pkt_r;
  logic [BYTE_OFFSET_WIDTH-1:0] offset;
  logic [DWORD_BYTES-1:0]       size_mask;

  assign offset = mmu_cmd_i.vaddr[BYTE_OFFSET_WIDTH-1:0];

  always_comb begin
    dec_pkt_n           = '0;
    dec_pkt_n.v         = mmu_cmd_v_i;
    dec_pkt_n.vaddr     = mmu_cmd_i.vaddr;
    case (mmu_cmd_i.mem_op)
      e_lb:    begin dec_pkt_n.size = e_byte;  dec_pkt_n.is_signed = 1'b1; end
      e_lh:    begin dec_pkt_n.size = e_half;  dec_pkt_n.is_signed = 1'b1; end
      e_lw:    begin dec_pkt_n.size = e_word;  dec_pkt_n.is_signed = 1'b1; end
      e_ld:    dec_pkt_n.size = e_dword;
      e_lbu:   dec_pkt_n.size = e_byte;
      e_lhu:   dec_pkt_n.size = e_half;
      e_lwu:   dec_pkt_n.size = e_word;
      e_sb:    begin dec_pkt_n.size = e_byte;  dec_pkt_n.is_store = 1'b1; end
      e_sh:    begin dec_pkt_n.size = e_half;  dec_pkt_n.is_store = 1'b1; end
      e_sw:    begin dec_pkt_n.size = e_word;  dec_pkt_n.is_store = 1'b1; end
      e_sd:    begin dec_pkt_n.size = e_dword; dec_pkt_n.is_store = 1'b1; end
      default: dec_pkt_n.size = e_byte;
    endcase

    case (dec_pkt_n.size)
      e_byte:  size_mask = 8'h01;
      e_half:  size_mask = 8'h03;
      e_word:  size_mask = 8'h0f;
      default: size_mask = 8'hff;
    endcase

    // Move store data and mask onto the addressed byte lanes
    dec_pkt_n.data = mmu_cmd_i.data << {offset, 3'b000};
    dec_pkt_n.mask = size_mask << offset;
  end

  always_ff @(posedge clk_i) begin
    dec_pkt_r <= dec_pkt_n;
    if (reset_i) begin
      dec_pkt_r.v <= 1'b0;
    end
  end

  assign dec_pkt_o = dec_pkt_r;

  a_known_op: assert property (@(posedge clk_i) disable iff (reset_i)
    mmu_cmd_v_i |-> mmu_cmd_i.mem_op inside {e_lb, e_lh, e_lw, e_ld, e_lbu, e_lhu,
                                             e_lwu, e_sb, e_sh, e_sw, e_sd})
    else $error("unknown mem_op %0h on a valid command", mmu_cmd_i.mem_op);

endmodule

`default_nettype wire

// File: src/mem_execute.sv
// Translate, check and access stage
`timescale 1ns/1ps
`default_nettype none

module mem_execute
  import mem_pkg::*;
#(
  parameter int tlb_els_p   = 4,
  parameter int ram_words_p = 128
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  dec_pkt_s               dec_pkt_i,
  input  mmu_cfg_s               cfg_i,
  input  logic                   chk_poison_i,
  input  logic                   tlb_fill_v_i,
  input  tlb_fill_s              tlb_fill_i,
  input  logic                   tlb_flush_i,
  output exe_pkt_s               exe_pkt_o,
  output logic [DWORD_WIDTH-1:0] ram_data_o
);

  localparam int ram_addr_width_lp = $clog2(ram_words_p);

  logic [VTAG_WIDTH-1:0]                   vtag;
  logic                                    tlb_hit;
  tlb_entry_s                              tlb_entry;
  logic [PTAG_WIDTH-1:0]                   ptag;
  logic [PTAG_WIDTH+PAGE_OFFSET_WIDTH-1:0] paddr;
  logic                                    miss;
  logic                                    priv_fault;
  logic                                    write_fault;
  logic                                    page_fault;
  logic                                    access_fault;
  fault_e                                  fault;
  logic                                    ram_we;
  exe_pkt_s                                exe_pkt_n;
  exe_pkt_s                                exe_pkt_r;

  assign vtag = dec_pkt_i.vaddr[VADDR_WIDTH-1 -: VTAG_WIDTH];

  dtlb #(
    .tlb_els_p (tlb_els_p)
  ) dtlb_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .flush_i  (tlb_flush_i),
    .fill_v_i (tlb_fill_v_i),
    .fill_i   (tlb_fill_i),
    .vtag_i   (vtag),
    .hit_o    (tlb_hit),
    .entry_o  (tlb_entry)
  );

  // Bare mode maps the low virtual tag bits straight through
  assign ptag  = cfg_i.translation_en ? tlb_entry.ptag : vtag[PTAG_WIDTH-1:0];
  assign paddr = {ptag, dec_pkt_i.vaddr[PAGE_OFFSET_WIDTH-1:0]};
  assign miss  = cfg_i.translation_en & ~tlb_hit;

  assign priv_fault  = ((cfg_i.priv == e_priv_s) & ~cfg_i.sum & tlb_entry.u)
                     | ((cfg_i.priv == e_priv_u) & ~tlb_entry.u);
  assign write_fault = dec_pkt_i.is_store & (~tlb_entry.w | ~tlb_entry.d);
  assign page_fault  = cfg_i.translation_en & tlb_hit & (priv_fault | write_fault);

  // Only domain zero is backed by the RAM
  assign access_fault = (ptag[PTAG_WIDTH-1 -: DID_WIDTH] != '0);

  always_comb begin
    if (miss) begin
      fault = e_no_fault;
    end else if (page_fault) begin
      fault = dec_pkt_i.is_store ? e_store_page_fault : e_load_page_fault;
    end else if (access_fault) begin
      fault = dec_pkt_i.is_store ? e_store_access_fault : e_load_access_fault;
    end else begin
      fault = e_no_fault;
    end
  end

  assign ram_we = dec_pkt_i.v & ~chk_poison_i & dec_pkt_i.is_store & ~miss
                & (fault == e_no_fault);

  data_ram #(
    .ram_words_p (ram_words_p)
  ) ram_i (
    .clk_i   (clk_i),
    .we_i    (ram_we),
    .addr_i  (paddr[BYTE_OFFSET_WIDTH +: ram_addr_width_lp]),
    .wdata_i (dec_pkt_i.data),
    .wmask_i (dec_pkt_i.mask),
    .rdata_o (ram_data_o)
  );

  always_comb begin
    exe_pkt_n.v         = dec_pkt_i.v & ~chk_poison_i;
    exe_pkt_n.is_store  = dec_pkt_i.is_store;
    exe_pkt_n.miss      = miss;
    exe_pkt_n.fault     = fault;
    exe_pkt_n.size      = dec_pkt_i.size;
    exe_pkt_n.is_signed = dec_pkt_i.is_signed;
    exe_pkt_n.offset    = dec_pkt_i.vaddr[BYTE_OFFSET_WIDTH-1:0];
  end

  always_ff @(posedge clk_i) begin
    exe_pkt_r <= exe_pkt_n;
    if (reset_i) begin
      exe_pkt_r.v <= 1'b0;
    end
  end

  assign exe_pkt_o = exe_pkt_r;

endmodule

`default_nettype wire

// File: src/mem_pkg.sv
// Memory stage shared types
`default_nettype none

package mem_pkg;

  localparam int VADDR_WIDTH       = 20;
  localparam int PAGE_OFFSET_WIDTH = 8;
  localparam int VTAG_WIDTH        = VADDR_WIDTH - PAGE_OFFSET_WIDTH;
  localparam int PTAG_WIDTH        = 6;
  localparam int DID_WIDTH         = 2;
  localparam int DWORD_WIDTH       = 64;
  localparam int DWORD_BYTES       = DWORD_WIDTH / 8;
  localparam int BYTE_OFFSET_WIDTH = $clog2(DWORD_BYTES);

  typedef enum logic [3:0] {
    e_lb, e_lh, e_lw, e_ld, e_lbu, e_lhu, e_lwu,
    e_sb, e_sh, e_sw, e_sd
  } mem_op_e;

  typedef enum logic [1:0] {
    e_byte, e_half, e_word, e_dword
  } size_e;

  // RISC-V privilege encoding
  typedef enum logic [1:0] {
    e_priv_u = 2'b00,
    e_priv_s = 2'b01,
    e_priv_m = 2'b11
  } priv_e;

  typedef enum logic [2:0] {
    e_no_fault, e_load_page_fault, e_store_page_fault,
    e_load_access_fault, e_store_access_fault
  } fault_e;

  typedef struct packed {
    mem_op_e                mem_op;
    logic [VADDR_WIDTH-1:0] vaddr;
    logic [DWORD_WIDTH-1:0] data;
  } mmu_cmd_s;

  typedef struct packed {
    logic  translation_en;
    priv_e priv;
    logic  sum;
  } mmu_cfg_s;

  // Leaf PTE bits kept in the TLB
  typedef struct packed {
    logic [PTAG_WIDTH-1:0] ptag;
    logic                  u;
    logic                  w;
    logic                  d;
  } tlb_entry_s;

  typedef struct packed {
    logic [VTAG_WIDTH-1:0] vtag;
    tlb_entry_s            entry;
  } tlb_fill_s;

  typedef struct packed {
    logic                   v;
    logic                   is_store;
    size_e                  size;
    logic                   is_signed;
    logic [VADDR_WIDTH-1:0] vaddr;
    logic [DWORD_WIDTH-1:0] data;
    logic [DWORD_BYTES-1:0] mask;
  } dec_pkt_s;

  typedef struct packed {
    logic                         v;
    logic                         is_store;
    logic                         miss;
    fault_e                       fault;
    size_e                        size;
    logic                         is_signed;
    logic [BYTE_OFFSET_WIDTH-1:0] offset;
  } exe_pkt_s;

  typedef struct packed {
    logic [DWORD_WIDTH-1:0] data;
    logic                   miss_v;
    logic                   exc_v;
    fault_e                 fault;
  } mem_resp_s;

endpackage

`default_nettype wire

// File: src/mem_result.sv
// Load data alignment and response
`timescale 1ns/1ps
`default_nettype none

module mem_result
  import mem_pkg::*;
(
  input  exe_pkt_s               exe_pkt_i,
  input  logic [DWORD_WIDTH-1:0] ram_data_i,
  output mem_resp_s              mem_resp_o,
  output logic                   mem_resp_v_o
);

  logic [DWORD_WIDTH-1:0] shifted;
  logic [DWORD_WIDTH-1:0] load_data;
  logic                   load_ok;

  assign shifted = ram_data_i >> {exe_pkt_i.offset, 3'b000};

  always_comb begin
    case (exe_pkt_i.size)
      e_byte: begin
        load_data = {{(DWORD_WIDTH-8){exe_pkt_i.is_signed & shifted[7]}}, shifted[7:0]};
      end
      e_half: begin
        load_data = {{(DWORD_WIDTH-16){exe_pkt_i.is_signed & shifted[15]}}, shifted[15:0]};
      end
      e_word: begin
        load_data = {{(DWORD_WIDTH-32){exe_pkt_i.is_signed & shifted[31]}}, shifted[31:0]};
      end
      default: begin
        load_data = shifted;
      end
    endcase
  end

  // Stores, misses and faults return no data
  assign load_ok = ~exe_pkt_i.is_store & ~exe_pkt_i.miss & (exe_pkt_i.fault == e_no_fault);

  always_comb begin
    mem_resp_o.data   = load_ok ? load_data : '0;
    mem_resp_o.miss_v = exe_pkt_i.miss;
    mem_resp_o.exc_v  = (exe_pkt_i.fault != e_no_fault);
    mem_resp_o.fault  = exe_pkt_i.fault;
  end

  assign mem_resp_v_o = exe_pkt_i.v;

  // Fault ranking upstream keeps a miss free of any fault
  always_comb begin
    if (mem_resp_v_o) begin
      a_miss_xor_exc: assert (!(mem_resp_o.miss_v && mem_resp_o.exc_v))
        else $error("response has both miss_v and exc_v set");
    end
  end

endmodule

`default_nettype wire

// File: src/mem_top.sv
// Data memory stage top
`timescale 1ns/1ps
`default_nettype none

module mem_top
  import mem_pkg::*;
#(
  parameter int tlb_els_p   = 4,
  parameter int ram_words_p = 128
) (
  input  logic      clk_i,
  input  logic      reset_i,

  input  mmu_cmd_s  mmu_cmd_i,
  input  logic      mmu_cmd_v_i,
  input  mmu_cfg_s  cfg_i,
  input  logic      chk_poison_i,

  input  logic      tlb_fill_v_i,
  input  tlb_fill_s tlb_fill_i,
  input  logic      tlb_flush_i,

  output mem_resp_s mem_resp_o,
  output logic      mem_resp_v_o
);

  dec_pkt_s               dec_pkt;
  exe_pkt_s               exe_pkt;
  logic [DWORD_WIDTH-1:0] ram_data;

  mem_decode decode_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .mmu_cmd_i   (mmu_cmd_i),
    .mmu_cmd_v_i (mmu_cmd_v_i),
    .dec_pkt_o   (dec_pkt)
  );

  mem_execute #(
    .tlb_els_p   (tlb_els_p),
    .ram_words_p (ram_words_p)
  ) execute_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .dec_pkt_i    (dec_pkt),
    .cfg_i        (cfg_i),
    .chk_poison_i (chk_poison_i),
    .tlb_fill_v_i (tlb_fill_v_i),
    .tlb_fill_i   (tlb_fill_i),
    .tlb_flush_i  (tlb_flush_i),
    .exe_pkt_o    (exe_pkt),
    .ram_data_o   (ram_data)
  );

  mem_result result_i (
    .exe_pkt_i    (exe_pkt),
    .ram_data_i   (ram_data),
    .mem_resp_o   (mem_resp_o),
    .mem_resp_v_o (mem_resp_v_o)
  );

endmodule

`default_nettype wire
